// File: run_monitor_pkg.sv
// Run monitor shared definitions
// Widths, status codes, display modes and the structs that carry
// core status, performance counts and display digits across the panel

package run_monitor_pkg;

	//========================================
	// Widths
	//========================================
	localparam int COUNT_WIDTH  = 32;	// Perf counter width
	localparam int ADDR_WIDTH   = 22;	// Fetch address
	localparam int PDF_WIDTH    = 16;	// Pass/fail/done value
	localparam int NIBBLE_WIDTH = 4;	// One hex digit
	localparam int SEG_WIDTH    = 7;	// Segments a..g
	localparam int NUM_DIGITS   = 8;	// Digits on the board

	// Status codes reported by the core
	typedef enum logic [1:0] {
		NOOP = 2'd0,	// Nothing to report
		PASS = 2'd1,	// Test passed
		FAIL = 2'd2,	// Test failed
		DONE = 2'd3		// Program finished
	} statusCode_t;

	// Switch-selected display modes
	typedef enum logic [1:0] {
		STATUS = 2'd0,	// Glyph, value and fetch address
		CYCLES = 2'd1,	// Cycle count
		INSTRS = 2'd2,	// Retired instruction count
		SPARE  = 2'd3	// Unused, shows zeros
	} dispMode_t;

	//========================================
	// Structs
	//========================================
	typedef struct packed {
		logic                  loaderDone;	// Program loaded
		logic                  retire;		// One instruction retired
		statusCode_t           pdfChange;	// Event code, NOOP when idle
		logic [PDF_WIDTH-1:0]  pdfValue;	// Value reported with the event
		logic [ADDR_WIDTH-1:0] fetchAddr;	// Current fetch address
	} coreStatus_t;

	typedef struct packed {
		logic [COUNT_WIDTH-1:0] cycleCount;
		logic [COUNT_WIDTH-1:0] instrCount;
	} perfCounts_t;

	// Digit 0 is the least significant nibble
	typedef logic [NUM_DIGITS-1:0][NIBBLE_WIDTH-1:0] nibbleBank_t;

endpackage

// File: perf_counters.sv
// Performance counters
// Counts cycles and retired instructions between loader completion
// and the DONE status code; the run-done flag is sticky so the
// counts stay frozen and readable after the run

`timescale 1ns/1ps

module perf_counters import run_monitor_pkg::*;
(
	input  logic        i_Clk,
	input  logic        Internal_Reset_n,
	input  coreStatus_t i_Status,		// Core status bundle
	output perfCounts_t o_Counts,		// Cycle and instruction counts
	output logic        o_RunDone		// Sticky, set by DONE
);

	logic runActive;	// Counting window
	logic doneEvent;	// DONE code this cycle

	// Loader finished and DONE not yet seen
	assign runActive = i_Status.loaderDone && !o_RunDone;
	assign doneEvent = (i_Status.pdfChange == DONE);

	//========================================
	// Counters and run-done flag
	//========================================
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			o_Counts  <= '0;
			o_RunDone <= 1'b0;
		end
		else
		begin
			// The DONE edge itself still counts
			if (runActive)
			begin
				o_Counts.cycleCount <= o_Counts.cycleCount + 1'b1;
				if (i_Status.retire)
				begin
					// One strobe per retired instruction
					o_Counts.instrCount <= o_Counts.instrCount + 1'b1;
				end
			end

			// Sticky until reset
			if (doneEvent)
				o_RunDone <= 1'b1;
		end
	end

endmodule

// File: display_select.sv
// Display source selector
// Latches the last reported status event and registers the eight
// digit nibbles for the switch-selected mode, plus the status code
// and the flag that lets digit 2 show the status glyph

`timescale 1ns/1ps

module display_select import run_monitor_pkg::*;
(
	input  logic        i_Clk,
	input  logic        Internal_Reset_n,
	input  coreStatus_t i_Status,
	input  perfCounts_t i_Counts,
	input  dispMode_t   i_Mode,			// From the switches
	output nibbleBank_t o_Nibbles,		// Registered digit contents
	output statusCode_t o_StatusCode,	// Last reported code
	output logic        o_ShowStatus	// Mode is STATUS, registered
);

	logic [PDF_WIDTH-1:0] statusValQ;		// Last reported value
	logic [PDF_WIDTH-1:0] statusValNext;
	statusCode_t          statusCodeNext;
	nibbleBank_t          nibblesNext;

	// An event replaces the held status, otherwise hold
	always_comb
	begin
		statusValNext  = statusValQ;
		statusCodeNext = o_StatusCode;
		if (i_Status.pdfChange != NOOP)
		begin
			statusValNext  = i_Status.pdfValue;
			statusCodeNext = i_Status.pdfChange;
		end
	end

	//========================================
	// Digit contents per mode
	//========================================
	always_comb
	begin
		nibblesNext = '0;	// Unused digits stay zero
		case (i_Mode)
			STATUS:
			begin
				// New event value shows without waiting for the latch
				nibblesNext[0] = statusValNext[3:0];
				nibblesNext[1] = statusValNext[7:4];
				nibblesNext[6] = i_Status.fetchAddr[3:0];	// Low PC byte
				nibblesNext[7] = i_Status.fetchAddr[7:4];
			end
			CYCLES:  nibblesNext = nibbleBank_t'(i_Counts.cycleCount);
			INSTRS:  nibblesNext = nibbleBank_t'(i_Counts.instrCount);
			default: nibblesNext = '0;	// SPARE
		endcase
	end

	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			statusValQ   <= '0;
			o_StatusCode <= NOOP;
			o_Nibbles    <= '0;
			o_ShowStatus <= 1'b0;
		end
		else
		begin
			statusValQ   <= statusValNext;
			o_StatusCode <= statusCodeNext;
			o_Nibbles    <= nibblesNext;
			o_ShowStatus <= (i_Mode == STATUS);
		end
	end

endmodule

// File: seg7_hex.sv
// Hex digit decoder
// Registered lookup from a nibble to active-low segments g..a

`timescale 1ns/1ps

module seg7_hex import run_monitor_pkg::*;
(
	input  logic                    i_Clk,
	input  logic                    Internal_Reset_n,
	input  logic [NIBBLE_WIDTH-1:0] i_Nibble,
	output logic [SEG_WIDTH-1:0]    o_Seg	// Low = segment lit
);

	logic [SEG_WIDTH-1:0] segNext;

	always_comb
	begin
		case (i_Nibble)
			4'h0: segNext = 7'b1000000;
			4'h1: segNext = 7'b1111001;
			4'h2: segNext = 7'b0100100;
			4'h3: segNext = 7'b0110000;
			4'h4: segNext = 7'b0011001;
			4'h5: segNext = 7'b0010010;
			4'h6: segNext = 7'b0000010;
			4'h7: segNext = 7'b1111000;
			4'h8: segNext = 7'b0000000;
			4'h9: segNext = 7'b0010000;
			4'hA: segNext = 7'b0001000;
			4'hB: segNext = 7'b0000011;	// Lower case b
			4'hC: segNext = 7'b1000110;
			4'hD: segNext = 7'b0100001;	// Lower case d
			4'hE: segNext = 7'b0000110;
			default: segNext = 7'b0001110;	// F
		endcase
	end

	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
			o_Seg <= 7'b1000000;	// Shows "0"
		else
			o_Seg <= segNext;
	end

endmodule

// File: seg7_panel.sv
// Seven-segment panel
// Eight hex decoders plus the pass/fail/done glyph decoder;
// in status mode the glyph takes over digit 2

`timescale 1ns/1ps

module seg7_panel import run_monitor_pkg::*;
(
	input  logic        i_Clk,
	input  logic        Internal_Reset_n,
	input  nibbleBank_t i_Nibbles,
	input  statusCode_t i_StatusCode,
	input  logic        i_ShowStatus,
	output logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] o_Hex	// Active-low segments
);

	logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] hexSeg;	// Decoded digits
	logic [SEG_WIDTH-1:0] glyphNext;
	logic [SEG_WIDTH-1:0] glyphQ;			// Registered status glyph
	logic                 showStatusQ;	// Aligned with the decoders

	//========================================
	// Hex decoders
	//========================================
	for (genvar d = 0; d < NUM_DIGITS; d++)
	begin : gen_digit
		seg7_hex u_hex (
			.i_Clk            (i_Clk),
			.Internal_Reset_n (Internal_Reset_n),
			.i_Nibble         (i_Nibbles[d]),
			.o_Seg            (hexSeg[d])
		);
	end

	// Status glyphs
	always_comb
	begin
		case (i_StatusCode)
			PASS:    glyphNext = 7'b0001100;	// P
			FAIL:    glyphNext = 7'b0001110;	// F
			DONE:    glyphNext = 7'b0100001;	// d
			default: glyphNext = 7'b0111111;	// Dash, middle bar only
		endcase
	end

	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			glyphQ      <= 7'b0111111;
			showStatusQ <= 1'b0;
		end
		else
		begin
			glyphQ      <= glyphNext;
			showStatusQ <= i_ShowStatus;	// Same edge as the hex digits
		end
	end

	// Digit 2 override in status mode
	always_comb
	begin
		o_Hex = hexSeg;
		if (showStatusQ)
			o_Hex[2] = glyphQ;
	end

endmodule

// File: run_monitor_top.sv
// Run monitor top level
// Front panel of the processor: performance counters, display
// source selection, seven-segment panel and the done/running LEDs

`timescale 1ns/1ps

module run_monitor_top import run_monitor_pkg::*;
(
	input  logic        i_Clk,
	input  logic        Internal_Reset_n,	// Async, active low
	input  coreStatus_t i_Status,			// Status reported by the core
	input  logic [1:0]  i_Sw,				// Display mode switches
	output logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] o_Hex,
	output logic        o_LedDone,
	output logic        o_LedRunning
);

	//========================================
	// Internal wiring
	//========================================
	perfCounts_t counts;		// Counter values
	logic        runDone;		// Sticky done flag
	nibbleBank_t nibbles;		// Selected digits
	statusCode_t statusCode;	// Last reported code
	logic        showStatus;	// Digit 2 takes the glyph

	perf_counters u_counters (
		.i_Clk            (i_Clk),
		.Internal_Reset_n (Internal_Reset_n),
		.i_Status         (i_Status),
		.o_Counts         (counts),
		.o_RunDone        (runDone)
	);

	display_select u_select (
		.i_Clk            (i_Clk),
		.Internal_Reset_n (Internal_Reset_n),
		.i_Status         (i_Status),
		.i_Counts         (counts),
		.i_Mode           (dispMode_t'(i_Sw)),	// Switches pick the mode
		.o_Nibbles        (nibbles),
		.o_StatusCode     (statusCode),
		.o_ShowStatus     (showStatus)
	);

	seg7_panel u_panel (
		.i_Clk            (i_Clk),
		.Internal_Reset_n (Internal_Reset_n),
		.i_Nibbles        (nibbles),
		.i_StatusCode     (statusCode),
		.i_ShowStatus     (showStatus),
		.o_Hex            (o_Hex)
	);

	// LEDs follow the registered done flag
	assign o_LedDone    = runDone;
	assign o_LedRunning = !runDone;	// Lit until DONE

endmodule

// File: run_monitor_checker.sv
// Run monitor checker
// Reference model of counters, latched status and display digits;
// compares o_Hex and the LEDs with the DUT at the fixed latencies

`timescale 1ns/1ps

module run_monitor_checker import run_monitor_pkg::*;
(
	input logic        i_Clk,
	input logic        Internal_Reset_n,
	input coreStatus_t i_Status,
	input logic [1:0]  i_Sw,
	input logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] o_Hex,
	input logic        o_LedDone,
	input logic        o_LedRunning
);

	// Active-low patterns, entry F first
	localparam logic [15:0][SEG_WIDTH-1:0] HEX_SEGS = {
		7'b0001110, 7'b0000110, 7'b0100001, 7'b1000110,
		7'b0000011, 7'b0001000, 7'b0010000, 7'b0000000,
		7'b1111000, 7'b0000010, 7'b0010010, 7'b0011001,
		7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000};
	localparam logic [3:0][SEG_WIDTH-1:0] GLYPHS = {	// d F P dash
		7'b0100001, 7'b0001110, 7'b0001100, 7'b0111111};

	int                                   errorCount = 0;	// Polled by the testbench
	logic [COUNT_WIDTH-1:0]               refCycles;
	logic [COUNT_WIDTH-1:0]               refInstrs;
	logic                                 refDone;
	logic [PDF_WIDTH-1:0]                 refValue;		// Last event value
	statusCode_t                          refCode;
	logic [PDF_WIDTH-1:0]                 valNow;
	statusCode_t                          codeNow;
	logic [NUM_DIGITS-1:0][3:0]           digits;
	logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] expNow;
	logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] expQ1;
	logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] expQ2;		// Two edges behind

	always_comb
	begin
		valNow  = (i_Status.pdfChange != NOOP) ? i_Status.pdfValue : refValue;
		codeNow = (i_Status.pdfChange != NOOP) ? i_Status.pdfChange : refCode;
		digits  = '0;
		case (i_Sw)
			2'd0:
			begin
				digits[1:0] = valNow[7:0];
				digits[7:6] = i_Status.fetchAddr[7:0];
			end
			2'd1:    digits = refCycles;
			2'd2:    digits = refInstrs;
			default: digits = '0;
		endcase
		for (int d = 0; d < NUM_DIGITS; d++)
			expNow[d] = HEX_SEGS[digits[d]];
		if (i_Sw == 2'd0)
			expNow[2] = GLYPHS[codeNow];	// Glyph replaces digit 2
	end

	//========================================
	// Reference model
	//========================================
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			refCycles <= '0;
			refInstrs <= '0;
			refDone   <= 1'b0;
			refValue  <= '0;
			refCode   <= NOOP;
			expQ1     <= {NUM_DIGITS{7'b1000000}};
			expQ2     <= {NUM_DIGITS{7'b1000000}};
		end
		else
		begin
			if (i_Status.loaderDone && !refDone)
			begin
				refCycles <= refCycles + 1;
				refInstrs <= refInstrs + COUNT_WIDTH'(i_Status.retire);
			end
			if (i_Status.pdfChange == DONE)
				refDone <= 1'b1;
			refValue <= valNow;
			refCode  <= codeNow;
			expQ1    <= expNow;
			expQ2    <= expQ1;
		end
	end

	a_hexDisplay: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		o_Hex == expQ2)
		else
		begin
			$error("MISMATCH hex_display: expected %h actual %h",
				$sampled(expQ2), $sampled(o_Hex));
			errorCount++;
		end

	a_ledDone: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		o_LedDone == refDone)
		else
		begin
			$error("MISMATCH led_done: expected %b actual %b",
				$sampled(refDone), $sampled(o_LedDone));
			errorCount++;
		end

	a_ledRunning: assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		o_LedRunning == !refDone)
		else
		begin
			$error("MISMATCH led_running: expected %b actual %b",
				!$sampled(refDone), $sampled(o_LedRunning));
			errorCount++;
		end

endmodule

bind run_monitor_top run_monitor_checker u_checker (
	.i_Clk            (i_Clk),
	.Internal_Reset_n (Internal_Reset_n),
	.i_Status         (i_Status),
	.i_Sw             (i_Sw),
	.o_Hex            (o_Hex),
	.o_LedDone        (o_LedDone),
	.o_LedRunning     (o_LedRunning)
);

// File: tb_run_monitor.sv
// Run monitor testbench
// Drives loader, retire and status events from an LFSR through every
// display mode; the bound checker compares the panel outputs

`timescale 1ns/1ps

module tb_run_monitor import run_monitor_pkg::*;
();

	localparam int MAX_CYCLES = 1500;	// Stimulus runs about 570 cycles

	logic        i_Clk = 1'b0;
	logic        Internal_Reset_n;
	coreStatus_t i_Status;
	logic [1:0]  i_Sw;
	logic [NUM_DIGITS-1:0][SEG_WIDTH-1:0] o_Hex;
	logic        o_LedDone;
	logic        o_LedRunning;

	logic [31:0] lfsr = 32'h7245_dc21;	// Stimulus source
	int          cycleNum = 0;

	run_monitor_top uut (
		.i_Clk            (i_Clk),
		.Internal_Reset_n (Internal_Reset_n),
		.i_Status         (i_Status),
		.i_Sw             (i_Sw),
		.o_Hex            (o_Hex),
		.o_LedDone        (o_LedDone),
		.o_LedRunning     (o_LedRunning)
	);

	always #4 i_Clk = ~i_Clk;	// 8 ns period

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic drawBits(input int n, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = stepLfsr(lfsr);
			bits = {bits[14:0], lfsr[0]};
		end
	endtask

	// n cycles in one mode with an optional event on the first cycle
	task automatic runCycles(input int n, input dispMode_t mode, input statusCode_t code);
		logic [15:0] bits;
		for (int c = 0; c < n; c++)
		begin
			@(posedge i_Clk);
			#1;
			i_Sw = mode;
			drawBits(1, bits);
			i_Status.retire = bits[0];			// Random retire strobe
			drawBits(16, bits);
			i_Status.fetchAddr[15:0] = bits;
			drawBits(16, bits);
			i_Status.pdfValue = bits;			// Only taken with an event
			if (c == 0)
				i_Status.pdfChange = code;
			else
				i_Status.pdfChange = NOOP;		// One-cycle event
		end
	endtask

	//========================================
	// Error polling and timeout
	//========================================
	always @(posedge i_Clk)
	begin
		cycleNum++;
		if (uut.u_checker.errorCount != 0)
		begin
			$display("Done: errors found");
			$fatal(1, "An assertion in the run monitor checker failed");
		end
		else if (cycleNum >= MAX_CYCLES)
		begin
			$display("Done: errors found");
			$fatal(1, "Timeout: the stimulus did not finish within %0d cycles", MAX_CYCLES);
		end
	end

	initial
	begin
		Internal_Reset_n = 1'b0;
		i_Status         = '0;
		i_Sw             = CYCLES;
		repeat (5) @(posedge i_Clk);
		#1;
		Internal_Reset_n = 1'b1;

		runCycles(30, CYCLES, NOOP);	// Loader busy so counts hold
		runCycles(20, INSTRS, NOOP);
		i_Status.loaderDone = 1'b1;
		for (int m = 0; m < 4; m++)
			runCycles(40, dispMode_t'(m), NOOP);

		// Alternating pass and fail events
		for (int k = 0; k < 12; k++)
			runCycles(15, STATUS, k[0] ? FAIL : PASS);

		runCycles(10, STATUS, DONE);	// Counters freeze here
		for (int m = 0; m < 4; m++)
			runCycles(40, dispMode_t'(m), NOOP);
		runCycles(4, SPARE, NOOP);		// Drain the display pipeline

		if (uut.u_checker.errorCount == 0)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("Done: errors found");
			$fatal(1, "The run monitor checker counted failed assertions");
		end
	end

endmodule

// File: list.f
run_monitor_pkg.sv
perf_counters.sv
display_select.sv
seg7_hex.sv
seg7_panel.sv
run_monitor_top.sv
run_monitor_checker.sv
tb_run_monitor.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the run monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_run_monitor -f list.f -o sim_run_monitor

output="$(./obj_dir/sim_run_monitor +verilator+error+limit+1000 2>&1 || true)"
echo "$output"

if grep -qx "Done: no errors" <<< "$output"; then
	exit 0
else
	exit 1
fi
